/* compile.f */
+incdir+include
source/isa_pkg.sv
source/core_pkg.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/result_unit.sv
source/core_top.sv
tests/core_top_properties.sv
tests/core_top_tb.sv

/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath width
`define XLEN 64

// instruction word width
`define INST_W 32

// register file shape
`define REG_ADDR_W 5
`define REG_COUNT 32

// instruction queue depth, also the sender's credits after reset
`define INST_QUEUE_DEPTH 4

// credits the result port starts with
`define RES_CREDITS 2

// width of the credit counters and the queue occupancy
// must hold INST_QUEUE_DEPTH
`define CREDIT_W 3

`endif

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, then scan the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_top_tb -f compile.f \
    -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vcore_top_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"
exit 0

/* source/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    // one data word
    typedef logic [`XLEN-1:0] xlen_t;

    // register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation carried from decode to execute
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui result is operand b as is
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

/* source/core_top.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  logic [`INST_W-1:0] inst,
    output logic               inst_credit,
    output logic               res_valid,
    output reg_addr_t          res_rd,
    output xlen_t              res_data,
    output logic               res_illegal,
    input  logic               res_credit
);

// register file ports
reg_addr_t rs1_addr;
reg_addr_t rs2_addr;
xlen_t     rs1_data;
xlen_t     rs2_data;

// decode to execute
logic      ex_valid;
logic      ex_ready;
alu_op_e   ex_alu_op;
xlen_t     ex_operand_a;
xlen_t     ex_operand_b;
reg_addr_t ex_rd;
logic      ex_dest_wen;
logic      ex_illegal;

// execute to result
logic      res_in_valid;
logic      res_in_ready;
reg_addr_t res_in_rd;
xlen_t     res_in_data;
logic      res_in_dest_wen;
logic      res_in_illegal;

// write-back
logic      wb_en;
reg_addr_t wb_rd;
xlen_t     wb_data;

decode_unit decode_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_credit  (inst_credit),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .ex_valid     (ex_valid),
    .ex_ready     (ex_ready),
    .ex_alu_op    (ex_alu_op),
    .ex_operand_a (ex_operand_a),
    .ex_operand_b (ex_operand_b),
    .ex_rd        (ex_rd),
    .ex_dest_wen  (ex_dest_wen),
    .ex_illegal   (ex_illegal)
);

reg_file reg_file_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
);

execute_unit execute_unit_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid        (ex_valid),
    .ex_ready        (ex_ready),
    .ex_alu_op       (ex_alu_op),
    .ex_operand_a    (ex_operand_a),
    .ex_operand_b    (ex_operand_b),
    .ex_rd           (ex_rd),
    .ex_dest_wen     (ex_dest_wen),
    .ex_illegal      (ex_illegal),
    .res_in_valid    (res_in_valid),
    .res_in_ready    (res_in_ready),
    .res_in_rd       (res_in_rd),
    .res_in_data     (res_in_data),
    .res_in_dest_wen (res_in_dest_wen),
    .res_in_illegal  (res_in_illegal)
);

result_unit result_unit_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .res_in_valid    (res_in_valid),
    .res_in_ready    (res_in_ready),
    .res_in_rd       (res_in_rd),
    .res_in_data     (res_in_data),
    .res_in_dest_wen (res_in_dest_wen),
    .res_in_illegal  (res_in_illegal),
    .res_valid       (res_valid),
    .res_rd          (res_rd),
    .res_data        (res_data),
    .res_illegal     (res_illegal),
    .res_credit      (res_credit),
    .wb_en           (wb_en),
    .wb_rd           (wb_rd),
    .wb_data         (wb_data)
);

endmodule

/* source/decode_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  logic [`INST_W-1:0] inst,
    output logic               inst_credit,
    output reg_addr_t          rs1_addr,
    output reg_addr_t          rs2_addr,
    input  xlen_t              rs1_data,
    input  xlen_t              rs2_data,
    input  logic               wb_en,
    input  reg_addr_t          wb_rd,
    output logic               ex_valid,
    input  logic               ex_ready,
    output alu_op_e            ex_alu_op,
    output xlen_t              ex_operand_a,
    output xlen_t              ex_operand_b,
    output reg_addr_t          ex_rd,
    output logic               ex_dest_wen,
    output logic               ex_illegal
);

localparam int ptr_w = $clog2(`INST_QUEUE_DEPTH);

logic [`INST_W-1:0]   queue [`INST_QUEUE_DEPTH];
logic [ptr_w-1:0]     wr_ptr;
logic [ptr_w-1:0]     rd_ptr;
logic [`CREDIT_W-1:0] q_count;
logic [`INST_W-1:0]   head;
logic [`REG_COUNT-1:0] busy;

opcode_e             opcode;
funct3_e             funct3;
logic [funct7_w-1:0] funct7;
reg_addr_t           rd_field;
xlen_t               imm_i;
xlen_t               imm_u;
xlen_t               shamt;
logic                alt;
logic                rs1_used;
logic                rs2_used;
logic                legal;
logic                hazard;
logic                issue;

// instruction queue
always_ff @(posedge clk) begin
    if (inst_valid) begin
        queue[wr_ptr] <= inst;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        wr_ptr  <= '0;
        rd_ptr  <= '0;
        q_count <= '0;
    end else begin
        if (inst_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        q_count <= q_count + {{(`CREDIT_W-1){1'b0}}, inst_valid}
                           - {{(`CREDIT_W-1){1'b0}}, issue};
    end
end

assign head     = queue[rd_ptr];
assign opcode   = opcode_e'(head[opcode_w-1:0]);
assign funct3   = funct3_e'(head[14:12]);
assign funct7   = head[31:25];
assign rd_field = head[11:7];
assign rs1_addr = head[19:15];
assign rs2_addr = head[24:20];
assign imm_i    = {{(`XLEN-12){head[31]}}, head[31:20]};
assign imm_u    = {{(`XLEN-32){head[31]}}, head[31:12], 12'b0};
assign shamt    = {{(`XLEN-6){1'b0}}, head[25:20]};

always_comb begin
    ex_alu_op    = alu_add;
    ex_operand_a = '0;
    ex_operand_b = '0;
    rs1_used     = 1'b0;
    rs2_used     = 1'b0;
    legal        = 1'b1;
    alt          = 1'b0;
    case (opcode)
        lui: begin
            ex_alu_op    = alu_pass_b;
            ex_operand_b = imm_u;
        end
        op, op_imm: begin
            rs1_used     = 1'b1;
            rs2_used     = (opcode == op);
            ex_operand_a = rs1_data;
            ex_operand_b = (opcode == op) ? rs2_data : imm_i;
            if (opcode == op) begin
                alt   = (funct7 == funct7_alt);
                legal = (funct7 == '0)
                     || (alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
            end else if (funct3 == f3_sll || funct3 == f3_srl_sra) begin
                // bit 25 belongs to the 6-bit shamt here
                alt          = (funct7[6:1] == funct7_alt[6:1]);
                legal        = (funct7[6:1] == '0) || (alt && funct3 == f3_srl_sra);
                ex_operand_b = shamt;
            end
            case (funct3)
                f3_add_sub: ex_alu_op = alt ? alu_sub : alu_add;
                f3_sll:     ex_alu_op = alu_sll;
                f3_slt:     ex_alu_op = alu_slt;
                f3_sltu:    ex_alu_op = alu_sltu;
                f3_xor:     ex_alu_op = alu_xor;
                f3_srl_sra: ex_alu_op = alt ? alu_sra : alu_srl;
                f3_or:      ex_alu_op = alu_or;
                default:    ex_alu_op = alu_and;
            endcase
        end
        default: legal = 1'b0;
    endcase
end

assign ex_rd       = rd_field;
assign ex_illegal  = !legal;
assign ex_dest_wen = legal && (rd_field != '0);

// a pending rd also blocks, otherwise the older write-back would clear the newer bit
assign hazard   = (legal && rs1_used && busy[rs1_addr])
               || (legal && rs2_used && busy[rs2_addr])
               || (ex_dest_wen && busy[rd_field]);
assign ex_valid = (q_count != '0) && !hazard;
assign issue    = ex_valid && ex_ready;

// scoreboard and credit return
always_ff @(posedge clk) begin
    if (!rst_n) begin
        busy        <= '0;
        inst_credit <= 1'b0;
    end else begin
        inst_credit <= issue;
        if (wb_en) begin
            busy[wb_rd] <= 1'b0;
        end
        if (issue && ex_dest_wen) begin
            busy[rd_field] <= 1'b1;
        end
    end
end

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ex_valid,
    output logic      ex_ready,
    input  alu_op_e   ex_alu_op,
    input  xlen_t     ex_operand_a,
    input  xlen_t     ex_operand_b,
    input  reg_addr_t ex_rd,
    input  logic      ex_dest_wen,
    input  logic      ex_illegal,
    output logic      res_in_valid,
    input  logic      res_in_ready,
    output reg_addr_t res_in_rd,
    output xlen_t     res_in_data,
    output logic      res_in_dest_wen,
    output logic      res_in_illegal
);

localparam int shamt_w = $clog2(`XLEN);

logic               valid_q;
alu_op_e            op_q;
xlen_t              a_q;
xlen_t              b_q;
reg_addr_t          rd_q;
logic               dest_wen_q;
logic               illegal_q;
logic [shamt_w-1:0] shamt;
xlen_t              alu_out;

// stage register frees up when empty or handed on this cycle
assign ex_ready = !valid_q || res_in_ready;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        valid_q <= 1'b0;
    end else if (ex_ready) begin
        valid_q <= ex_valid;
    end
end

always_ff @(posedge clk) begin
    if (ex_valid && ex_ready) begin
        op_q       <= ex_alu_op;
        a_q        <= ex_operand_a;
        b_q        <= ex_operand_b;
        rd_q       <= ex_rd;
        dest_wen_q <= ex_dest_wen;
        illegal_q  <= ex_illegal;
    end
end

assign shamt = b_q[shamt_w-1:0];

always_comb begin
    case (op_q)
        alu_add:    alu_out = a_q + b_q;
        alu_sub:    alu_out = a_q - b_q;
        alu_sll:    alu_out = a_q << shamt;
        alu_slt:    alu_out = {{(`XLEN-1){1'b0}}, $signed(a_q) < $signed(b_q)};
        alu_sltu:   alu_out = {{(`XLEN-1){1'b0}}, a_q < b_q};
        alu_xor:    alu_out = a_q ^ b_q;
        alu_srl:    alu_out = a_q >> shamt;
        alu_sra:    alu_out = xlen_t'($signed(a_q) >>> shamt);
        alu_or:     alu_out = a_q | b_q;
        alu_and:    alu_out = a_q & b_q;
        alu_pass_b: alu_out = b_q;
        default:    alu_out = '0;
    endcase
end

assign res_in_valid    = valid_q;
assign res_in_rd       = rd_q;
assign res_in_data     = illegal_q ? '0 : alu_out;
assign res_in_dest_wen = dest_wen_q;
assign res_in_illegal  = illegal_q;

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

    // instruction field widths
    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;

    // funct7 value that selects sub and sra
    localparam logic [funct7_w-1:0] funct7_alt = 7'b0100000;

    // major opcodes handled by the core
    typedef enum logic [opcode_w-1:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111
    } opcode_e;

    // funct3 of the integer ALU group
    typedef enum logic [funct3_w-1:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_e;

endpackage

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  xlen_t     wb_data
);

xlen_t regs [`REG_COUNT];

// x0 is never written, so it stays at its reset value of zero
always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
        end
    end else if (wb_en && wb_rd != '0) begin
        regs[wb_rd] <= wb_data;
    end
end

// asynchronous read ports
assign rs1_data = regs[rs1_addr];
assign rs2_data = regs[rs2_addr];

endmodule

/* source/result_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module result_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      res_in_valid,
    output logic      res_in_ready,
    input  reg_addr_t res_in_rd,
    input  xlen_t     res_in_data,
    input  logic      res_in_dest_wen,
    input  logic      res_in_illegal,
    output logic      res_valid,
    output reg_addr_t res_rd,
    output xlen_t     res_data,
    output logic      res_illegal,
    input  logic      res_credit,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data
);

logic                 valid_q;
reg_addr_t            rd_q;
xlen_t                data_q;
logic                 dest_wen_q;
logic                 illegal_q;
logic [`CREDIT_W-1:0] credit_cnt;
logic                 retire;

// retire only with an output credit in hand
assign retire       = valid_q && (credit_cnt != '0);
assign res_in_ready = !valid_q || retire;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        valid_q    <= 1'b0;
        credit_cnt <= `CREDIT_W'(`RES_CREDITS);
    end else begin
        if (res_in_ready) begin
            valid_q <= res_in_valid;
        end
        credit_cnt <= credit_cnt + {{(`CREDIT_W-1){1'b0}}, res_credit}
                                 - {{(`CREDIT_W-1){1'b0}}, retire};
    end
end

always_ff @(posedge clk) begin
    if (res_in_valid && res_in_ready) begin
        rd_q       <= res_in_rd;
        data_q     <= res_in_data;
        dest_wen_q <= res_in_dest_wen;
        illegal_q  <= res_in_illegal;
    end
end

assign res_valid   = retire;
assign res_rd      = rd_q;
assign res_data    = data_q;
assign res_illegal = illegal_q;

// write-back on the same edge the result leaves
assign wb_en   = retire && dest_wen_q;
assign wb_rd   = rd_q;
assign wb_data = data_q;

endmodule

/* tests/core_top_properties.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 inst_valid,
    input logic                 inst_credit,
    input logic                 res_valid,
    input logic                 res_credit,
    input logic                 wb_en,
    input logic [`CREDIT_W-1:0] q_count
);

logic [`CREDIT_W-1:0] port_credits;

// output credits as seen at the core_top ports
always_ff @(posedge clk) begin
    if (!rst_n) begin
        port_credits <= `CREDIT_W'(`RES_CREDITS);
    end else begin
        port_credits <= port_credits + {{(`CREDIT_W-1){1'b0}}, res_credit}
                                     - {{(`CREDIT_W-1){1'b0}}, res_valid};
    end
end

// queue occupancy bounded by its depth
queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
    q_count <= `CREDIT_W'(`INST_QUEUE_DEPTH))
    else $error("instruction queue holds more entries than its depth");

// no write into a full queue
full_write: assert property (@(posedge clk) disable iff (!rst_n)
    (q_count == `CREDIT_W'(`INST_QUEUE_DEPTH)) |-> !inst_valid)
    else $error("instruction written into a full queue");

// a result leaves only with an output credit
res_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> (port_credits != '0))
    else $error("result sent with no output credit");

// outputs quiet while held in reset
reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!inst_credit && !res_valid && !wb_en))
    else $error("handshake outputs active during reset");

endmodule

bind core_top core_top_properties core_top_properties_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_valid  (inst_valid),
    .inst_credit (inst_credit),
    .res_valid   (res_valid),
    .res_credit  (res_credit),
    .wb_en       (result_unit_inst.wb_en),
    .q_count     (decode_unit_inst.q_count)
);

/* tests/core_top_tb.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top_tb;

localparam int num_tests      = 15;
localparam int timeout_cycles = num_tests * 20 + 100;

logic                   clk;
logic                   rst_n;
logic                   inst_valid = 1'b0;
logic [`INST_W-1:0]     inst = '0;
logic                   res_credit = 1'b0;
logic                   inst_credit;
logic                   res_valid;
logic [`REG_ADDR_W-1:0] res_rd;
logic [`XLEN-1:0]       res_data;
logic                   res_illegal;

// stimulus and expected results
logic [`INST_W-1:0]     tbl_inst [num_tests];
logic [`REG_ADDR_W-1:0] tbl_rd [num_tests];
logic [`XLEN-1:0]       tbl_data [num_tests];
logic                   tbl_illegal [num_tests];
string                  tbl_name [num_tests];

int     agent_credits = `INST_QUEUE_DEPTH;
int     results_seen = 0;
int     credits_returned = 0;
int     check_count = 0;
int     value_errors = 0;
int     flow_errors = 0;
int     credit_errors = 0;
int     end_errors = 0;
int     timeouts = 0;
int     cycle_count = 0;
int     consumer_cycle = 0;
int     credit_due [$];
int     due_idx;
int     delay;
integer seed = 32'hdf7c;

core_top core_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_credit (inst_credit),
    .res_valid   (res_valid),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .res_illegal (res_illegal),
    .res_credit  (res_credit)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

function automatic logic [31:0] encode_r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encode_i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] encode_u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
endfunction

task automatic add_test(input int idx, input logic [31:0] word, input logic [4:0] rd,
                        input logic [63:0] data, input logic illegal, input string name);
    tbl_inst[idx]    = word;
    tbl_rd[idx]      = rd;
    tbl_data[idx]    = data;
    tbl_illegal[idx] = illegal;
    tbl_name[idx]    = name;
endtask

task automatic load_table();
    add_test(0, encode_u_type(20'h12345, 5'd1), 5'd1, 64'h0000_0000_1234_5000, 1'b0, "lui");
    add_test(1, encode_i_type(12'hffb, 5'd0, 3'b000, 5'd2), 5'd2, 64'hffff_ffff_ffff_fffb,
             1'b0, "addi");
    // reads x2 straight after its write
    add_test(2, encode_r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 64'h0000_0000_1234_4ffb,
             1'b0, "add_dep");
    add_test(3, encode_r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 5'd4, 64'hffff_ffff_ffff_fffb,
             1'b0, "sub_dep");
    add_test(4, encode_r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 5'd5, 64'h0000_0000_1234_5000,
             1'b0, "and");
    add_test(5, encode_i_type(12'h0ff, 5'd1, 3'b110, 5'd6), 5'd6, 64'h0000_0000_1234_50ff,
             1'b0, "ori");
    add_test(6, encode_r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, 64'hffff_ffff_edcb_affb,
             1'b0, "xor");
    add_test(7, encode_r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 5'd8, 64'd1, 1'b0, "slt_neg");
    add_test(8, encode_r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd9), 5'd9, 64'd0, 1'b0, "sltu_neg");
    add_test(9, encode_i_type(12'h004, 5'd1, 3'b001, 5'd10), 5'd10, 64'h0000_0001_2345_0000,
             1'b0, "slli");
    add_test(10, encode_i_type(12'h03c, 5'd2, 3'b101, 5'd11), 5'd11, 64'h0000_0000_0000_000f,
             1'b0, "srli");
    add_test(11, encode_i_type(12'h401, 5'd2, 3'b101, 5'd12), 5'd12, 64'hffff_ffff_ffff_fffd,
             1'b0, "srai");
    // unknown opcode 7f aimed at x5
    add_test(12, 32'h0000_02ff, 5'd5, 64'd0, 1'b1, "illegal");
    add_test(13, encode_i_type(12'h007, 5'd1, 3'b000, 5'd0), 5'd0, 64'h0000_0000_1234_5007,
             1'b0, "addi_x0");
    // x0 must read zero, x5 keeps the and result
    add_test(14, encode_r_type(7'h00, 5'd5, 5'd0, 3'b000, 5'd13), 5'd13,
             64'h0000_0000_1234_5000, 1'b0, "add_x0_x5");
endtask

// credits left once this edge's send and return are counted
function automatic int credits_after_edge();
    return agent_credits - (inst_valid ? 1 : 0) + (inst_credit ? 1 : 0);
endfunction

task automatic finish_run();
    int total;
    total = value_errors + flow_errors + credit_errors + end_errors + timeouts;
    $display("%0d checks, errors: value %0d, flow %0d, credit %0d, end %0d, timeout %0d",
             check_count, value_errors, flow_errors, credit_errors, end_errors, timeouts);
    if (total == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
endtask

// sender credit count
always @(posedge clk) begin
    if (!rst_n) begin
        agent_credits <= `INST_QUEUE_DEPTH;
    end else begin
        agent_credits <= credits_after_edge();
        assert (credits_after_edge() >= 0 && credits_after_edge() <= `INST_QUEUE_DEPTH) else begin
            $display("instruction credits out of range: %0d", credits_after_edge());
            credit_errors++;
        end
    end
end

// consumer returns a credit 0 to 3 cycles after each result
always @(posedge clk) begin
    if (!rst_n) begin
        res_credit <= 1'b0;
    end else begin
        consumer_cycle++;
        if (res_valid) begin
            delay = $unsigned($random(seed)) % 4;
            credit_due.push_back(consumer_cycle + delay);
        end
        due_idx = -1;
        foreach (credit_due[k]) begin
            if (due_idx < 0 && credit_due[k] <= consumer_cycle) begin
                due_idx = k;
            end
        end
        if (due_idx >= 0) begin
            credit_due.delete(due_idx);
            res_credit <= 1'b1;
        end else begin
            res_credit <= 1'b0;
        end
    end
end

// in-order result checks
always @(posedge clk) begin
    if (rst_n) begin
        if (res_valid) begin
            assert (results_seen < credits_returned + `RES_CREDITS) else begin
                $display("result %0d sent beyond the output credits returned", results_seen);
                flow_errors++;
            end
            if (results_seen < num_tests) begin
                check_count++;
                assert (res_rd === tbl_rd[results_seen]) else begin
                    $display("Fail %s rd: expected %0d, actual %0d", tbl_name[results_seen],
                             tbl_rd[results_seen], res_rd);
                    value_errors++;
                end
                assert (res_data === tbl_data[results_seen]) else begin
                    $display("Fail %s data: expected %h, actual %h", tbl_name[results_seen],
                             tbl_data[results_seen], res_data);
                    value_errors++;
                end
                assert (res_illegal === tbl_illegal[results_seen]) else begin
                    $display("Fail %s illegal: expected %0b, actual %0b", tbl_name[results_seen],
                             tbl_illegal[results_seen], res_illegal);
                    value_errors++;
                end
            end else begin
                $display("extra result beyond the table, rd %0d", res_rd);
                flow_errors++;
            end
            results_seen++;
        end
        if (res_credit) begin
            credits_returned++;
        end
    end
end

initial begin
    while (cycle_count < timeout_cycles) begin
        @(posedge clk);
        cycle_count++;
    end
    timeouts = 1;
    $display("Timeout after %0d cycles with %0d of %0d results received",
             cycle_count, results_seen, num_tests);
    finish_run();
end

initial begin
    rst_n = 1'b0;
    load_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < num_tests; i++) begin
        @(posedge clk);
        while (credits_after_edge() == 0) begin
            inst_valid <= 1'b0;
            @(posedge clk);
        end
        inst_valid <= 1'b1;
        inst       <= tbl_inst[i];
    end
    @(posedge clk);
    inst_valid <= 1'b0;

    wait (results_seen == num_tests);
    // room for any stray result or late credit
    repeat (8) @(posedge clk);
    assert (agent_credits == `INST_QUEUE_DEPTH) else begin
        $display("Fail final agent credits: expected %0d, actual %0d",
                 `INST_QUEUE_DEPTH, agent_credits);
        end_errors++;
    end
    finish_run();
end

endmodule
